/* hdl/dpPkg.sv */
package dpPkg;

    localparam int dataWidth    = 32;
    localparam int regCount     = 16;
    localparam int regAddrWidth = 4;

    typedef logic [regAddrWidth-1:0] regAddrT;
    typedef logic [dataWidth-1:0]    wordT;

    // ARM data-processing opcodes, bits 24:21
    typedef enum logic [3:0] {
        opAnd = 4'd0,
        opEor = 4'd1,
        opSub = 4'd2,
        opRsb = 4'd3,
        opAdd = 4'd4,
        opAdc = 4'd5,
        opSbc = 4'd6,
        opRsc = 4'd7,
        opTst = 4'd8,
        opTeq = 4'd9,
        opCmp = 4'd10,
        opCmn = 4'd11,
        opOrr = 4'd12,
        opMov = 4'd13,
        opBic = 4'd14,
        opMvn = 4'd15
    } aluOpT;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    // bits 3:0 of imm8 double as the second source register
    typedef struct packed {
        logic [5:0] upper;   // cond and class, ignored
        logic       immFlag;
        aluOpT      op;
        logic       setFlags;
        regAddrT    rn;
        regAddrT    rd;
        logic [3:0] rotate;  // no rotation here
        logic [7:0] imm8;
    } instrT;

    typedef struct packed {
        aluOpT   op;
        logic    setFlags;
        logic    writes;
        regAddrT rd;
        wordT    a;
        wordT    b;
    } operandT;

    typedef struct packed {
        regAddrT rd;
        logic    writes;
        wordT    value;
        flagsT   flags;
    } resultT;

endpackage

/* hdl/pipeReg.sv */
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    Clk,
    input  logic    reset,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    full;
    payloadT data;

    assign inReady  = !full || outReady; // free, or draining this cycle
    assign outValid = full;
    assign outData  = data;

    always_ff @(posedge Clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (inValid && inReady) begin
            full <= 1'b1;
        end else if (outReady) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (inValid && inReady) data <= inData; // payload only
    end

    // a refused record must stay put until the slot takes it
    assert property (@(posedge Clk) disable iff (reset)
        inValid && !inReady |=> inValid && $stable(inData))
        else $error("pipeReg input changed before it was taken");

endmodule

/* hdl/registerFile.sv */
`timescale 1ns/1ps

module registerFile import dpPkg::*; (
    input  logic    Clk,
    input  logic    reset,
    input  regAddrT rdAddrA,
    input  regAddrT rdAddrB,
    output wordT    rdDataA,
    output wordT    rdDataB,
    input  logic    wrEn,
    input  regAddrT wrAddr,
    input  wordT    wrData
);

    wordT regs [regCount];

    // asynchronous read ports
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge Clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // writeback address comes from the execute stage
    assert property (@(posedge Clk) disable iff (reset)
        wrEn |-> !$isunknown(wrAddr))
        else $error("register write with unknown address");

endmodule

/* hdl/operandFetch.sv */
`timescale 1ns/1ps

module operandFetch import dpPkg::*; (
    input  instrT   instr,
    output regAddrT rdAddrA,
    output regAddrT rdAddrB,
    input  wordT    rdDataA,
    input  wordT    rdDataB,
    input  logic    fwdValid,
    input  regAddrT fwdAddr,
    input  wordT    fwdData,
    output operandT operand
);

    logic isCompare;
    wordT regA;
    wordT regB;
    wordT immWord;

    // TST, TEQ, CMP, CMN occupy 8..11
    assign isCompare = (instr.op[3:2] == 2'b10);

    assign rdAddrA = instr.rn;
    assign rdAddrB = instr.imm8[3:0]; // rm field

    // the record in execute has not reached the register file yet
    always_comb begin
        regA = rdDataA;
        regB = rdDataB;
        if (fwdValid && fwdAddr == rdAddrA) regA = fwdData;
        if (fwdValid && fwdAddr == rdAddrB) regB = fwdData;
    end

    assign immWord = {{(dataWidth-8){1'b0}}, instr.imm8}; // zero-extended

    always_comb begin
        operand.op       = instr.op;
        operand.setFlags = instr.setFlags || isCompare;
        operand.writes   = !isCompare;
        operand.rd       = instr.rd;
        operand.a        = regA;
        operand.b        = instr.immFlag ? immWord : regB;
    end

endmodule

/* hdl/aluCore.sv */
`timescale 1ns/1ps

module aluCore import dpPkg::*; (
    input  aluOpT op,
    input  wordT  a,
    input  wordT  b,
    input  flagsT flagsIn,
    output wordT  result,
    output flagsT flagsOut
);

    wordT             addX;
    wordT             addY;
    logic             addCin;
    logic             arith;
    logic [dataWidth:0] sum;
    logic             overflow;

    // every add or subtract form goes through one adder
    // subtract is x + ~y + 1, so the carry out is ARM's no-borrow C
    always_comb begin
        addX   = a;
        addY   = b;
        addCin = 1'b0;
        arith  = 1'b1;
        case (op)
            opSub, opCmp: begin
                addY   = ~b;
                addCin = 1'b1;
            end
            opRsb: begin
                addX   = b;
                addY   = ~a;
                addCin = 1'b1;
            end
            opAdc:   addCin = flagsIn.c;
            opSbc: begin
                addY   = ~b;
                addCin = flagsIn.c; // extra one off when C clear
            end
            opRsc: begin
                addX   = b;
                addY   = ~a;
                addCin = flagsIn.c;
            end
            opAdd, opCmn: arith = 1'b1;
            default: arith = 1'b0;
        endcase
    end

    assign sum      = {1'b0, addX} + {1'b0, addY} + {{dataWidth{1'b0}}, addCin};
    assign overflow = (addX[dataWidth-1] == addY[dataWidth-1]) &&
                      (sum[dataWidth-1] != addX[dataWidth-1]);

    always_comb begin
        case (op)
            opAnd, opTst: result = a & b;
            opEor, opTeq: result = a ^ b;
            opOrr:        result = a | b;
            opMov:        result = b;
            opBic:        result = a & ~b;
            opMvn:        result = ~b;
            default:      result = sum[dataWidth-1:0];
        endcase
    end

    assign flagsOut.n = result[dataWidth-1];
    assign flagsOut.z = (result == '0);
    assign flagsOut.c = arith ? sum[dataWidth] : flagsIn.c; // logical forms keep C, V
    assign flagsOut.v = arith ? overflow : flagsIn.v;

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/1ps

module executeStage import dpPkg::*; (
    input  logic    Clk,
    input  logic    reset,
    input  operandT operand,
    input  logic    operandValid,
    input  logic    accept,
    output resultT  result,
    output logic    wrEn,
    output regAddrT wrAddr,
    output wordT    wrData,
    output logic    fwdValid,
    output regAddrT fwdAddr,
    output wordT    fwdData
);

    flagsT flagsQ;
    flagsT aluFlags;
    flagsT nextFlags;
    wordT  aluResult;

    aluCore alu (
        .op      (operand.op),
        .a       (operand.a),
        .b       (operand.b),
        .flagsIn (flagsQ),
        .result  (aluResult),
        .flagsOut(aluFlags)
    );

    assign nextFlags = operand.setFlags ? aluFlags : flagsQ;

    // flags move with the record into the result slot
    always_ff @(posedge Clk) begin
        if (reset) begin
            flagsQ <= '0;
        end else if (accept) begin
            flagsQ <= nextFlags;
        end
    end

    assign result = '{rd: operand.rd, writes: operand.writes,
                      value: aluResult, flags: nextFlags};

    // writeback lands on the same edge as the result slot load
    assign wrEn   = accept && operand.writes;
    assign wrAddr = operand.rd;
    assign wrData = aluResult;

    assign fwdValid = operandValid && operand.writes;
    assign fwdAddr  = operand.rd;
    assign fwdData  = aluResult;

    // accept comes from the result slot handshake at the top level
    assert property (@(posedge Clk) disable iff (reset)
        $rose(wrEn) |-> operandValid)
        else $error("register write without a valid record");

endmodule

/* hdl/dpCore.sv */
`timescale 1ns/1ps

module dpCore import dpPkg::*; (
    input  logic   Clk,
    input  logic   reset,
    input  logic   inValid,
    output logic   inReady,
    input  instrT  inInstr,
    output logic   outValid,
    input  logic   outReady,
    output resultT outResult
);

    regAddrT rdAddrA, rdAddrB;
    wordT    rdDataA, rdDataB;
    operandT fetchOperand;
    operandT execOperand;
    logic    execValid;
    logic    execReady;
    logic    accept;
    resultT  execResult;
    logic    wrEn;
    regAddrT wrAddr;
    wordT    wrData;
    logic    fwdValid;
    regAddrT fwdAddr;
    wordT    fwdData;

    assign accept = execValid && execReady; // result slot input transfer

    operandFetch fetch (
        .instr(inInstr), .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
        .fwdValid, .fwdAddr, .fwdData, .operand(fetchOperand)
    );

    registerFile regFile (
        .Clk, .reset, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
        .wrEn, .wrAddr, .wrData
    );

    pipeReg #(.payloadT(operandT)) fetchSlot (
        .Clk, .reset, .inValid, .inReady, .inData(fetchOperand),
        .outValid(execValid), .outReady(execReady), .outData(execOperand)
    );

    executeStage execute (
        .Clk, .reset, .operand(execOperand), .operandValid(execValid), .accept,
        .result(execResult), .wrEn, .wrAddr, .wrData, .fwdValid, .fwdAddr, .fwdData
    );

    pipeReg #(.payloadT(resultT)) resultSlot (
        .Clk, .reset, .inValid(execValid), .inReady(execReady), .inData(execResult),
        .outValid, .outReady, .outData(outResult)
    );

endmodule

/* tb/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic Clk,
    output logic reset
);

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk; // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge Clk);
        @(negedge Clk) reset = 1'b0; // released away from the sampling edge
    end

endmodule

/* tb/dpCoreTb.sv */
`timescale 1ns/1ps

module dpCoreTb import dpPkg::*; ();

    localparam int totalInstr = 16 + 300 + 200 + 100 + 300 + 80;

    logic   Clk;
    logic   reset;
    logic   inValid;
    logic   inReady;
    instrT  inInstr;
    logic   outValid;
    logic   outReady;
    resultT outResult;

    logic [31:0] rngState = 32'd17;
    logic        randomReady = 1'b0;
    wordT        modelRegs [regCount];
    flagsT       modelFlags;
    resultT      expectedQ [$]; // predicted results in acceptance order
    int          acceptedCount = 0;
    int          retiredCount = 0;
    int          checkCount = 0;
    int          errorCount = 0;

    clockGen clocks (.Clk, .reset);

    dpCore DUT (
        .Clk, .reset, .inValid, .inReady, .inInstr,
        .outValid, .outReady, .outResult
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // {c, v, sum}
    function automatic logic [33:0] addWith(input wordT x, input wordT y, input logic cin);
        logic [32:0] wide;
        wide = {1'b0, x} + {1'b0, y} + {32'b0, cin};
        return {wide[32], (x[31] == y[31]) && (wide[31] != x[31]), wide[31:0]};
    endfunction

    // {c, v, difference}, C means no borrow
    function automatic logic [33:0] subWith(input wordT x, input wordT y, input logic borrow);
        wordT diff;
        logic noBorrow;
        diff = x - y - {31'b0, borrow};
        noBorrow = ({1'b0, x} >= {1'b0, y} + {32'b0, borrow});
        return {noBorrow, (x[31] != y[31]) && (diff[31] != x[31]), diff};
    endfunction

    task automatic applyModel(input instrT ins);
        wordT        a;
        wordT        b;
        logic [33:0] alu;
        logic        compare;
        resultT      want;
        a = modelRegs[ins.rn];
        b = ins.immFlag ? {24'b0, ins.imm8} : modelRegs[ins.imm8[3:0]];
        compare = ins.op inside {opTst, opTeq, opCmp, opCmn};
        alu = {modelFlags.c, modelFlags.v, 32'b0}; // logical forms keep C and V
        case (ins.op)
            opAnd, opTst: alu[31:0] = a & b;
            opEor, opTeq: alu[31:0] = a ^ b;
            opOrr:        alu[31:0] = a | b;
            opMov:        alu[31:0] = b;
            opBic:        alu[31:0] = a & ~b;
            opMvn:        alu[31:0] = ~b;
            opAdd, opCmn: alu = addWith(a, b, 1'b0);
            opAdc:        alu = addWith(a, b, modelFlags.c);
            opSub, opCmp: alu = subWith(a, b, 1'b0);
            opRsb:        alu = subWith(b, a, 1'b0);
            opSbc:        alu = subWith(a, b, !modelFlags.c);
            opRsc:        alu = subWith(b, a, !modelFlags.c);
        endcase
        if (ins.setFlags || compare) begin
            modelFlags = '{n: alu[31], z: (alu[31:0] == 0), c: alu[33], v: alu[32]};
        end
        want = '{rd: ins.rd, writes: !compare, value: alu[31:0], flags: modelFlags};
        if (!compare) modelRegs[ins.rd] = alu[31:0];
        expectedQ.push_back(want);
    endtask

    task automatic checkField(input string name, input logic [31:0] want,
                              input logic [31:0] got);
        checkCount++;
        assert (got === want) else begin
            $display("Error at %0t ns: outResult.%s expected %h, got %h",
                     $time, name, want, got);
            errorCount++;
        end
    endtask

    // transfers on both sides, seen at the rising edge
    always @(posedge Clk) begin
        resultT want;
        if (!reset) begin
            assert (!(acceptedCount - retiredCount == 2 && !outReady && inReady)) else begin
                $display("inReady high at %0t ns while two results are waiting", $time);
                errorCount++;
            end
            if (outValid && outReady) begin
                assert (expectedQ.size() > 0) else begin
                    $display("a result came out at %0t ns with no instruction pending", $time);
                    errorCount++;
                end
                if (expectedQ.size() > 0) begin
                    want = expectedQ.pop_front();
                    checkField("rd", want.rd, outResult.rd);
                    checkField("writes", want.writes, outResult.writes);
                    checkField("value", want.value, outResult.value);
                    checkField("flags", want.flags, outResult.flags);
                end
                retiredCount++;
            end
            if (inValid && inReady) begin
                applyModel(inInstr);
                acceptedCount++;
            end
        end
    end

    task automatic stepCycle();
        logic [31:0] r;
        @(negedge Clk);
        r = nextRand();
        outReady = randomReady ? r[0] : 1'b1;
    endtask

    task automatic sendInstr(input instrT ins);
        int target;
        target = acceptedCount + 1;
        inValid = 1'b1;
        inInstr = ins;
        do stepCycle(); while (acceptedCount < target);
    endtask

    task automatic drain();
        inValid = 1'b0;
        while (expectedQ.size() != 0) stepCycle();
    endtask

    function automatic instrT randomInstr(input logic immFlag);
        instrT ins;
        ins = nextRand();
        ins.immFlag = immFlag;
        return ins;
    endfunction

    task automatic report(input int number, input string name, input int errorsBefore);
        $display("test %0d %s: %0d errors", number, name, errorCount - errorsBefore);
    endtask

    initial begin
        int          startErrors;
        instrT       ins;
        regAddrT     prevRd;
        regAddrT     compareRd;
        logic [31:0] r;
        inValid = 1'b0;
        inInstr = '0;
        outReady = 1'b1;
        modelFlags = '0;
        for (int i = 0; i < regCount; i++) modelRegs[i] = '0;
        wait (!reset);
        @(negedge Clk);

        startErrors = errorCount;
        checkCount++;
        assert (outValid === 1'b0 && inReady === 1'b1) else begin
            $display("after reset outValid is not low or inReady is not high");
            errorCount++;
        end
        for (int i = 0; i < regCount; i++) begin
            ins = '0;
            ins.op = opMov;
            ins.rd = regAddrT'(i);
            ins.imm8 = 8'(i); // rm = i
            sendInstr(ins);
        end
        drain();
        report(1, "reset state", startErrors);

        startErrors = errorCount;
        for (int i = 0; i < 300; i++) sendInstr(randomInstr(1'b0));
        drain();
        report(2, "register operands", startErrors);

        startErrors = errorCount;
        for (int i = 0; i < 200; i++) sendInstr(randomInstr(1'b1));
        drain();
        report(3, "immediate operands", startErrors);

        startErrors = errorCount;
        prevRd = '0;
        for (int i = 0; i < 100; i++) begin
            ins = randomInstr(1'b0);
            ins.rn = prevRd;
            ins.imm8[3:0] = prevRd; // both sources hit the last destination
            prevRd = ins.rd;
            sendInstr(ins);
        end
        drain();
        report(4, "dependent chains", startErrors);

        startErrors = errorCount;
        randomReady = 1'b1;
        for (int i = 0; i < 300; i++) begin
            r = nextRand();
            sendInstr(randomInstr(r[0]));
        end
        drain();
        randomReady = 1'b0;
        outReady = 1'b1;
        report(5, "back-pressure", startErrors);

        startErrors = errorCount;
        for (int i = 0; i < 40; i++) begin
            r = nextRand();
            ins = randomInstr(r[0]);
            ins.op = aluOpT'({2'b10, r[2:1]}); // TST..CMN
            compareRd = ins.rd;
            sendInstr(ins);
            ins = randomInstr(1'b0);
            ins.op = opMov;
            ins.setFlags = 1'b0;
            ins.imm8[3:0] = compareRd;
            sendInstr(ins);
        end
        drain();
        report(6, "compare forms", startErrors);

        checkCount++;
        assert (acceptedCount == totalInstr && retiredCount == totalInstr) else begin
            $display("instruction count wrong: %0d accepted, %0d returned",
                     acceptedCount, retiredCount);
            errorCount++;
        end
        $display("tests 6, checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // generous bound of 8 cycles per instruction
    initial begin
        repeat (totalInstr * 8 + 20) @(posedge Clk);
        $display("watchdog expired after %0d cycles", totalInstr * 8 + 20);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* dpCore.f */
hdl/dpPkg.sv
hdl/pipeReg.sv
hdl/registerFile.sv
hdl/operandFetch.sv
hdl/aluCore.sv
hdl/executeStage.sv
hdl/dpCore.sv
tb/clockGen.sv
tb/dpCoreTb.sv

/* Bender.yml */
package:
  name: dpcore

sources:
  - hdl/dpPkg.sv
  - hdl/pipeReg.sv
  - hdl/registerFile.sv
  - hdl/operandFetch.sv
  - hdl/aluCore.sv
  - hdl/executeStage.sv
  - hdl/dpCore.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/dpCoreTb.sv
